// ==== source/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    // Byte address and transaction ID widths of the fetch port.
    localparam int ADDR_W = 32;
    localparam int ID_W   = 4;

    // A cache line is filled from several memory beats.
    localparam int FILL_DW    = 32;
    localparam int LINE_W     = 128;
    localparam int BEATS      = LINE_W / FILL_DW;
    localparam int LINE_ALIGN = $clog2(LINE_W / 8);

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
    } fetch_req_t;

    typedef struct packed {
        logic [31:0]     data;
        logic            error;
        logic [ID_W-1:0] id;
    } fetch_rsp_t;

    // The full fetch address travels with a refill, so the word offset
    // is still known when the line comes back.
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
    } refill_req_t;

    typedef struct packed {
        logic [LINE_W-1:0] line;
        logic              error;
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
    } refill_rsp_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
    } mem_req_t;

    typedef struct packed {
        logic [FILL_DW-1:0] data;
        logic               error;
        logic               last;
    } mem_beat_t;

endpackage

`default_nettype wire

// ==== source/icache_id_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_id_queue #(
    parameter int DEPTH  = 4,
    parameter int DATA_W = icache_pkg::ID_W + icache_pkg::ADDR_W
) (
    input  wire logic              clk_i,
    input  wire logic              rst_ni,
    input  wire logic              push_i,
    input  wire logic [DATA_W-1:0] data_i,
    input  wire logic              pop_i,
    output logic      [DATA_W-1:0] data_o,
    output logic                   full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_W-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;

    assign data_o = mem_q[rd_ptr_q];
    assign full_o = (count_q == CNT_W'(DEPTH));

    // Storage is written in issue order and read from the head.
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // A push and a pop in the same cycle leave the count unchanged.
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/icache_line_assembler.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_line_assembler (
    input  wire logic                         clk_i,
    input  wire logic                         rst_ni,
    input  wire logic                         beat_valid_i,
    input  wire logic [icache_pkg::FILL_DW-1:0] beat_data_i,
    output logic      [icache_pkg::LINE_W-1:0]  line_o
);

    import icache_pkg::*;

    localparam int LOW_W = LINE_W - FILL_DW;

    // Holds every beat of the line except the one on the bus right now.
    logic [LOW_W-1:0] low_q;

    // The current beat sits on top, so after the last beat the first one
    // has been pushed all the way down to the lowest word.
    assign line_o = {beat_data_i, low_q};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            low_q <= '0;
        end else if (beat_valid_i) begin
            low_q <= line_o[LINE_W-1:FILL_DW];
        end
    end

endmodule

`default_nettype wire

// ==== source/icache_refill.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_refill #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,

    input  wire icache_pkg::refill_req_t refill_req_i,
    input  wire logic                    refill_req_valid_i,
    output logic                         refill_req_ready_o,

    output icache_pkg::refill_rsp_t      refill_rsp_o,
    output logic                         refill_rsp_valid_o,
    input  wire logic                    refill_rsp_ready_i,

    output icache_pkg::mem_req_t         mem_req_o,
    output logic                         mem_req_valid_o,
    input  wire logic                    mem_req_ready_i,

    input  wire icache_pkg::mem_beat_t   mem_beat_i,
    input  wire logic                    mem_beat_valid_i,
    output logic                         mem_beat_ready_o
);

    import icache_pkg::*;

    logic         queue_full;
    logic         queue_push;
    logic         queue_pop;
    refill_req_t  head_req;
    logic         beat_acc;
    logic         err_q;
    logic [LINE_W-1:0] line;

    // The queue remembers ID and fetch address of every burst in flight.
    icache_id_queue #(
        .DEPTH  (QUEUE_DEPTH),
        .DATA_W ($bits(refill_req_t))
    ) i_id_queue (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .push_i (queue_push),
        .data_i (refill_req_i),
        .pop_i  (queue_pop),
        .data_o (head_req),
        .full_o (queue_full)
    );

    // Bursts always cover a whole aligned line.
    assign mem_req_o.addr     = {refill_req_i.addr[ADDR_W-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};
    assign mem_req_o.len      = 8'(BEATS - 1);
    assign mem_req_valid_o    = refill_req_valid_i & ~queue_full;
    assign refill_req_ready_o = mem_req_ready_i & ~queue_full;
    assign queue_push         = mem_req_valid_o & mem_req_ready_i;

    assign beat_acc = mem_beat_valid_i & mem_beat_ready_o;

    icache_line_assembler i_line_assembler (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .beat_valid_i (beat_acc),
        .beat_data_i  (mem_beat_i.data),
        .line_o       (line)
    );

    // Error flags of the earlier beats of the burst are collected here
    // and cleared once the last beat goes out.
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            err_q <= 1'b0;
        end else if (beat_acc) begin
            err_q <= mem_beat_i.last ? 1'b0 : (err_q | mem_beat_i.error);
        end
    end

    assign refill_rsp_o.line  = line;
    assign refill_rsp_o.error = err_q | mem_beat_i.error;
    assign refill_rsp_o.id    = head_req.id;
    assign refill_rsp_o.addr  = head_req.addr;

    // Middle beats are taken at once. The last beat waits for the response
    // handshake, and only then is the head popped.
    always_comb begin
        refill_rsp_valid_o = 1'b0;
        mem_beat_ready_o   = 1'b0;
        queue_pop          = 1'b0;
        if (mem_beat_valid_i) begin
            if (!mem_beat_i.last) begin
                mem_beat_ready_o = 1'b1;
            end else begin
                refill_rsp_valid_o = 1'b1;
                mem_beat_ready_o   = refill_rsp_ready_i;
                queue_pop          = refill_rsp_ready_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/icache_lookup.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_lookup #(
    parameter int SETS = 16
) (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,

    input  wire icache_pkg::fetch_req_t  fetch_req_i,
    input  wire logic                    fetch_req_valid_i,
    output logic                         fetch_req_ready_o,

    output icache_pkg::fetch_rsp_t       fetch_rsp_o,
    output logic                         fetch_rsp_valid_o,
    input  wire logic                    fetch_rsp_ready_i,

    output icache_pkg::refill_req_t      refill_req_o,
    output logic                         refill_req_valid_o,
    input  wire logic                    refill_req_ready_i,

    input  wire icache_pkg::refill_rsp_t refill_rsp_i,
    input  wire logic                    refill_rsp_valid_i,
    output logic                         refill_rsp_ready_o
);

    import icache_pkg::*;

    localparam int INDEX_W = $clog2(SETS);
    localparam int TAG_W   = ADDR_W - LINE_ALIGN - INDEX_W;
    localparam int WORD_W  = $clog2(BEATS);

    logic [TAG_W-1:0]  tag_q   [SETS];
    logic [LINE_W-1:0] data_q  [SETS];
    logic [SETS-1:0]   valid_q;

    fetch_rsp_t  rsp_q;
    logic        rsp_valid_q;
    refill_req_t refill_req_q;
    logic        refill_req_valid_q;

    logic [INDEX_W-1:0] fetch_idx;
    logic [TAG_W-1:0]   fetch_tag;
    logic [WORD_W-1:0]  fetch_word;
    logic               hit;
    logic               fetch_acc;
    logic               refill_acc;

    logic [INDEX_W-1:0] fill_idx;
    logic [TAG_W-1:0]   fill_tag;
    logic [WORD_W-1:0]  fill_word;

    assign fetch_idx  = fetch_req_i.addr[LINE_ALIGN +: INDEX_W];
    assign fetch_tag  = fetch_req_i.addr[ADDR_W-1 -: TAG_W];
    assign fetch_word = fetch_req_i.addr[LINE_ALIGN-1 -: WORD_W];
    assign hit        = valid_q[fetch_idx] && (tag_q[fetch_idx] == fetch_tag);

    assign fill_idx  = refill_rsp_i.addr[LINE_ALIGN +: INDEX_W];
    assign fill_tag  = refill_rsp_i.addr[ADDR_W-1 -: TAG_W];
    assign fill_word = refill_rsp_i.addr[LINE_ALIGN-1 -: WORD_W];

    // A pending refill response owns the response register for its cycle,
    // so no fetch is taken while one is offered.
    assign refill_rsp_ready_o = ~rsp_valid_q;
    assign fetch_req_ready_o  = ~rsp_valid_q & ~refill_req_valid_q & ~refill_rsp_valid_i;

    assign refill_acc = refill_rsp_valid_i & refill_rsp_ready_o;
    assign fetch_acc  = fetch_req_valid_i & fetch_req_ready_o;

    assign fetch_rsp_o        = rsp_q;
    assign fetch_rsp_valid_o  = rsp_valid_q;
    assign refill_req_o       = refill_req_q;
    assign refill_req_valid_o = refill_req_valid_q;

    // A line that came back with an error is answered but never stored.
    always_ff @(posedge clk_i) begin
        if (refill_acc && !refill_rsp_i.error) begin
            tag_q[fill_idx]  <= fill_tag;
            data_q[fill_idx] <= refill_rsp_i.line;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (refill_acc && !refill_rsp_i.error) begin
            valid_q[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (refill_acc) begin
            rsp_q.data  <= refill_rsp_i.line[fill_word*FILL_DW +: FILL_DW];
            rsp_q.error <= refill_rsp_i.error;
            rsp_q.id    <= refill_rsp_i.id;
        end else if (fetch_acc && hit) begin
            rsp_q.data  <= data_q[fetch_idx][fetch_word*FILL_DW +: FILL_DW];
            rsp_q.error <= 1'b0;
            rsp_q.id    <= fetch_req_i.id;
        end
        if (fetch_acc && !hit) begin
            refill_req_q.addr <= fetch_req_i.addr;
            refill_req_q.id   <= fetch_req_i.id;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_valid_q        <= 1'b0;
            refill_req_valid_q <= 1'b0;
        end else begin
            if (rsp_valid_q && fetch_rsp_ready_i) begin
                rsp_valid_q <= 1'b0;
            end
            if (refill_acc || (fetch_acc && hit)) begin
                rsp_valid_q <= 1'b1;
            end
            if (refill_req_valid_q && refill_req_ready_i) begin
                refill_req_valid_q <= 1'b0;
            end
            if (fetch_acc && !hit) begin
                refill_req_valid_q <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/icache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_top #(
    parameter int QUEUE_DEPTH = 4,
    parameter int SETS        = 16
) (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,

    input  wire icache_pkg::fetch_req_t fetch_req_i,
    input  wire logic                   fetch_req_valid_i,
    output logic                        fetch_req_ready_o,

    output icache_pkg::fetch_rsp_t      fetch_rsp_o,
    output logic                        fetch_rsp_valid_o,
    input  wire logic                   fetch_rsp_ready_i,

    output icache_pkg::mem_req_t        mem_req_o,
    output logic                        mem_req_valid_o,
    input  wire logic                   mem_req_ready_i,

    input  wire icache_pkg::mem_beat_t  mem_beat_i,
    input  wire logic                   mem_beat_valid_i,
    output logic                        mem_beat_ready_o
);

    import icache_pkg::*;

    refill_req_t refill_req;
    logic        refill_req_valid;
    logic        refill_req_ready;
    refill_rsp_t refill_rsp;
    logic        refill_rsp_valid;
    logic        refill_rsp_ready;

    icache_lookup #(
        .SETS (SETS)
    ) i_lookup (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .fetch_req_i        (fetch_req_i),
        .fetch_req_valid_i  (fetch_req_valid_i),
        .fetch_req_ready_o  (fetch_req_ready_o),
        .fetch_rsp_o        (fetch_rsp_o),
        .fetch_rsp_valid_o  (fetch_rsp_valid_o),
        .fetch_rsp_ready_i  (fetch_rsp_ready_i),
        .refill_req_o       (refill_req),
        .refill_req_valid_o (refill_req_valid),
        .refill_req_ready_i (refill_req_ready),
        .refill_rsp_i       (refill_rsp),
        .refill_rsp_valid_i (refill_rsp_valid),
        .refill_rsp_ready_o (refill_rsp_ready)
    );

    // Misses leave through the refill engine, which owns the memory port.
    icache_refill #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_refill (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .refill_req_i       (refill_req),
        .refill_req_valid_i (refill_req_valid),
        .refill_req_ready_o (refill_req_ready),
        .refill_rsp_o       (refill_rsp),
        .refill_rsp_valid_o (refill_rsp_valid),
        .refill_rsp_ready_i (refill_rsp_ready),
        .mem_req_o          (mem_req_o),
        .mem_req_valid_o    (mem_req_valid_o),
        .mem_req_ready_i    (mem_req_ready_i),
        .mem_beat_i         (mem_beat_i),
        .mem_beat_valid_i   (mem_beat_valid_i),
        .mem_beat_ready_o   (mem_beat_ready_o)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_icache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_icache_top;

    import icache_pkg::*;

    localparam int NUM_ENTRIES = 16;
    localparam int QUEUE_DEPTH = 4;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
        logic              drain;
        logic              miss;
        fetch_rsp_t        exp;
    } entry_t;

    logic       clk_i = 1'b0;
    logic       rst_ni;
    fetch_req_t fetch_req_i;
    logic       fetch_req_valid_i;
    logic       fetch_req_ready_o;
    fetch_rsp_t fetch_rsp_o;
    logic       fetch_rsp_valid_o;
    logic       fetch_rsp_ready_i = 1'b0;
    mem_req_t   mem_req_o;
    logic       mem_req_valid_o;
    logic       mem_req_ready_i = 1'b1;
    mem_beat_t  mem_beat_i = '0;
    logic       mem_beat_valid_i = 1'b0;
    logic       mem_beat_ready_o;

    entry_t             stim [NUM_ENTRIES];
    fetch_rsp_t         expected_rsp [2**ID_W];
    logic [2**ID_W-1:0] issued = '0;
    logic [2**ID_W-1:0] received = '0;
    int                 issued_count = 0;
    int                 answered_count = 0;
    // Expected bursts in miss order, and bursts the memory model still has to return.
    mem_req_t           exp_req [NUM_ENTRIES];
    int                 exp_wr = 0;
    int                 exp_rd = 0;
    logic [ADDR_W-1:0]  burst_addr [NUM_ENTRIES];
    int                 burst_wr = 0;
    int                 burst_rd = 0;
    int                 bursts_done = 0;
    int                 beats_taken = 0;
    int                 beats_sent = 0;
    int                 beat_idx = 0;
    int                 gap = 0;
    logic [ADDR_W-1:0]  word_addr;

    icache_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .SETS        (16)
    ) icache_top_i (.*);

    initial begin
        forever #50 clk_i = ~clk_i;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_fetch_rsp(input fetch_rsp_t got, input fetch_rsp_t exp);
        if (got.data != exp.data) begin
            fail_run($sformatf("Mismatch fetch_rsp_o.data (id %h): got %h, expected %h",
                               exp.id, got.data, exp.data));
        end else if (got.error != exp.error) begin
            fail_run($sformatf("Mismatch fetch_rsp_o.error (id %h): got %h, expected %h",
                               exp.id, got.error, exp.error));
        end
    endtask

    task automatic check_mem_req(input mem_req_t got, input mem_req_t exp);
        if (got.addr != exp.addr) begin
            fail_run($sformatf("Mismatch mem_req_o.addr: got %h, expected %h", got.addr, exp.addr));
        end else if (got.len != exp.len) begin
            fail_run($sformatf("Mismatch mem_req_o.len: got %h, expected %h", got.len, exp.len));
        end
    endtask

    // Memory holds A XOR C0DE_0000 at byte address A. Lines with address bit 31 set fail.
    function automatic entry_t make_entry(input int idx, input logic [ADDR_W-1:0] addr,
                                          input logic drain, input logic miss);
        entry_t e;
        e.addr      = addr;
        e.id        = ID_W'(idx);
        e.drain     = drain;
        e.miss      = miss;
        e.exp.data  = {addr[ADDR_W-1:2], 2'b00} ^ 32'hC0DE_0000;
        e.exp.error = addr[ADDR_W-1];
        e.exp.id    = e.id;
        return e;
    endfunction

    task automatic issue_fetch(input entry_t e);
        fetch_req_i.addr      = e.addr;
        fetch_req_i.id        = e.id;
        fetch_req_valid_i     = 1'b1;
        issued[e.id]          = 1'b1;
        expected_rsp[e.id]    = e.exp;
        issued_count++;
        if (e.miss) begin
            exp_req[exp_wr].addr = e.addr & ~ADDR_W'(LINE_W / 8 - 1);
            exp_req[exp_wr].len  = 8'(BEATS - 1);
            exp_wr++;
        end
        @(posedge clk_i);
        while (!fetch_req_ready_o) begin
            @(posedge clk_i);
        end
        @(negedge clk_i);
        fetch_req_valid_i = 1'b0;
    endtask

    task automatic wait_for_drain();
        while (answered_count != issued_count) begin
            @(negedge clk_i);
        end
        if (exp_rd != exp_wr) begin
            fail_run("A fetch that should have missed issued no memory burst");
        end
    endtask

    // Handshakes are sampled on the rising edge.
    always @(posedge clk_i) begin
        if (rst_ni) begin
            if (mem_req_valid_o && mem_req_ready_i) begin
                if (exp_rd == exp_wr) begin
                    fail_run("A memory burst was issued for a fetch that should have hit");
                end else if (burst_wr - bursts_done >= QUEUE_DEPTH) begin
                    fail_run("More memory bursts are outstanding than the refill queue holds");
                end else begin
                    check_mem_req(mem_req_o, exp_req[exp_rd]);
                    exp_rd++;
                    burst_addr[burst_wr] = mem_req_o.addr;
                    burst_wr++;
                end
            end
            if (mem_beat_valid_i && mem_beat_ready_o) begin
                beats_taken++;
                if (mem_beat_i.last) begin
                    bursts_done++;
                end
            end
            if (fetch_rsp_valid_o && fetch_rsp_ready_i) begin
                if (!issued[fetch_rsp_o.id] || received[fetch_rsp_o.id]) begin
                    fail_run("A fetch response carries an ID with no pending fetch");
                end else begin
                    check_fetch_rsp(fetch_rsp_o, expected_rsp[fetch_rsp_o.id]);
                    received[fetch_rsp_o.id] = 1'b1;
                    answered_count++;
                end
            end
        end
    end

    // Memory model and fetch_rsp back-pressure, driven on the falling edge.
    initial begin
        void'($urandom(3));
        forever begin
            @(negedge clk_i);
            fetch_rsp_ready_i = ($urandom_range(3) != 0);
            if (mem_beat_valid_i && beats_taken == beats_sent) begin
                mem_beat_valid_i = 1'b0;
                if (mem_beat_i.last) begin
                    burst_rd++;
                    beat_idx = 0;
                end else begin
                    beat_idx++;
                end
                gap = $urandom_range(3);
            end
            if (!mem_beat_valid_i) begin
                if (gap > 0) begin
                    gap--;
                end else if (burst_rd != burst_wr) begin
                    word_addr        = burst_addr[burst_rd] + ADDR_W'(beat_idx * (FILL_DW / 8));
                    mem_beat_i.data  = word_addr ^ 32'hC0DE_0000;
                    mem_beat_i.error = word_addr[ADDR_W-1];
                    mem_beat_i.last  = (beat_idx == BEATS - 1);
                    mem_beat_valid_i = 1'b1;
                    beats_sent++;
                end
            end
        end
    end

    initial begin
        repeat (200 * NUM_ENTRIES) @(posedge clk_i);
        fail_run("Timeout: the fetch table did not complete in time");
    end

    initial begin
        rst_ni            = 1'b0;
        fetch_req_i       = '0;
        fetch_req_valid_i = 1'b0;
        // Cold miss, then a hit on the same line.
        stim[0]  = make_entry(0, 32'h0000_1004, 1'b1, 1'b1);
        stim[1]  = make_entry(1, 32'h0000_100C, 1'b1, 1'b0);
        // Misses to five sets fill the queue, and a hit slips in between.
        stim[2]  = make_entry(2, 32'h0000_2018, 1'b1, 1'b1);
        stim[3]  = make_entry(3, 32'h0000_3024, 1'b0, 1'b1);
        stim[4]  = make_entry(4, 32'h0000_4038, 1'b0, 1'b1);
        stim[5]  = make_entry(5, 32'h0000_504C, 1'b0, 1'b1);
        stim[6]  = make_entry(6, 32'h0000_6050, 1'b0, 1'b1);
        stim[7]  = make_entry(7, 32'h0000_1008, 1'b0, 1'b0);
        // An errored line is never installed, so it misses twice.
        stim[8]  = make_entry(8, 32'h8000_0074, 1'b1, 1'b1);
        stim[9]  = make_entry(9, 32'h8000_0074, 1'b1, 1'b1);
        // Two tags on set 8 evict each other.
        stim[10] = make_entry(10, 32'h0000_7080, 1'b1, 1'b1);
        stim[11] = make_entry(11, 32'h0000_9084, 1'b1, 1'b1);
        stim[12] = make_entry(12, 32'h0000_7088, 1'b1, 1'b1);
        stim[13] = make_entry(13, 32'h0000_908C, 1'b1, 1'b1);
        stim[14] = make_entry(14, 32'h0000_2014, 1'b1, 1'b0);
        stim[15] = make_entry(15, 32'h0000_3028, 1'b0, 1'b0);
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (stim[i].drain) begin
                wait_for_drain();
            end
            issue_fetch(stim[i]);
        end
        wait_for_drain();
        if (burst_rd != burst_wr) begin
            fail_run("The memory model still holds bursts that were never returned");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== icache_top.f ====
source/icache_pkg.sv
source/icache_id_queue.sv
source/icache_line_assembler.sv
source/icache_refill.sv
source/icache_lookup.sv
source/icache_top.sv
testbench/tb_icache_top.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it. The exit status is the simulation's.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ns -f icache_top.f \
    --top-module tb_icache_top -o sim_icache
./obj_dir/sim_icache
